/* common/vga_pkg.sv */
package vga_pkg;

    // 800x600 at 60 Hz with a 40 MHz pixel clock.
    localparam int HOR_PIXELS     = 800;
    localparam int HOR_TOTAL      = 1056;
    localparam int HOR_SYNC_START = 840;
    localparam int HOR_SYNC_END   = 968;

    localparam int VER_PIXELS     = 600;
    localparam int VER_TOTAL      = 628;
    localparam int VER_SYNC_START = 601;
    localparam int VER_SYNC_END   = 605;

    // sync pulses are active high in this mode.
    typedef struct packed {
        logic [10:0] hcount;
        logic [9:0]  vcount;
        logic        hsync;
        logic        vsync;
        logic        hblnk;
        logic        vblnk;
        logic [11:0] rgb;
    } vga_bus_t;

endpackage

/* common/game_pkg.sv */
package game_pkg;

    typedef enum logic [1:0] {MENU, PLAYING, OVER} game_state_t;
    typedef enum logic [1:0] {CLASS_NONE, CLASS_MELEE, CLASS_ARCHER} char_class_t;
    typedef enum logic [1:0] {WPN_NONE, WPN_SWORD, WPN_GUN} weapon_t;

    typedef struct packed {
        char_class_t cls;
        logic [3:0]  hp;
        weapon_t     wpn;
    } char_stats_t;

    typedef struct packed {
        logic        click;
        logic [11:0] x;
        logic [11:0] y;
    } mouse_evt_t;

    localparam int RECT_W   = 39;
    localparam int RECT_H   = 53;
    localparam int LEFT_X   = vga_pkg::HOR_PIXELS / 3;
    localparam int RIGHT_X  = vga_pkg::HOR_PIXELS * 2 / 3;
    localparam int CENTER_X = (vga_pkg::HOR_PIXELS - RECT_W) / 2;
    localparam int TOP_Y    = vga_pkg::VER_PIXELS * 2 / 3;
    localparam int CENTER_Y = TOP_Y + RECT_H / 2;
    localparam int FRAME_W  = 2;

    localparam logic [11:0] FRAME_COLOR = 12'hfff;
    localparam logic [11:0] BG_COLOR    = 12'h124;

    localparam logic [3:0] MELEE_HP  = 4'd10;
    localparam logic [3:0] ARCHER_HP = 4'd8;

    // a rectangle covers x0 <= x < x1 and y0 <= y < y1 inside the sprite.
    typedef struct packed {
        logic [7:0]  x0;
        logic [7:0]  y0;
        logic [7:0]  x1;
        logic [7:0]  y1;
        logic [11:0] color;
    } rect_t;

    localparam int N_RECTS = 3;

    // blade, crossguard, grip.
    localparam rect_t MELEE_RECTS [0:N_RECTS-1] = '{
        '{x0: 8'd17, y0: 8'd4,  x1: 8'd22, y1: 8'd36, color: 12'hccd},
        '{x0: 8'd9,  y0: 8'd36, x1: 8'd30, y1: 8'd40, color: 12'ha80},
        '{x0: 8'd17, y0: 8'd40, x1: 8'd22, y1: 8'd50, color: 12'h630}
    };

    // bow stave, string, arrow.
    localparam rect_t ARCHER_RECTS [0:N_RECTS-1] = '{
        '{x0: 8'd8,  y0: 8'd3,  x1: 8'd12, y1: 8'd50, color: 12'h852},
        '{x0: 8'd24, y0: 8'd5,  x1: 8'd25, y1: 8'd48, color: 12'heee},
        '{x0: 8'd10, y0: 8'd25, x1: 8'd34, y1: 8'd28, color: 12'hb22}
    };

endpackage

/* hw/vga_timing.sv */
`timescale 1ns/1ps

module vga_timing (
    input  logic              clk,
    input  logic              rst,
    output vga_pkg::vga_bus_t vga
);
    import vga_pkg::*;
    import game_pkg::*;

    logic [10:0] h_nxt;
    logic [9:0]  v_nxt;
    vga_bus_t    vga_nxt;

    always_comb begin
        h_nxt = vga.hcount + 11'd1;
        v_nxt = vga.vcount;
        if (vga.hcount == 11'(HOR_TOTAL - 1)) begin
            h_nxt = '0;
            if (vga.vcount == 10'(VER_TOTAL - 1)) begin
                v_nxt = '0;
            end else begin
                v_nxt = vga.vcount + 10'd1;
            end
        end
    end

    // sync and blanking are derived from the next count so they line up with it.
    always_comb begin
        vga_nxt.hcount = h_nxt;
        vga_nxt.vcount = v_nxt;
        vga_nxt.hsync  = (h_nxt >= HOR_SYNC_START) && (h_nxt < HOR_SYNC_END);
        vga_nxt.vsync  = (v_nxt >= VER_SYNC_START) && (v_nxt < VER_SYNC_END);
        vga_nxt.hblnk  = (h_nxt >= HOR_PIXELS);
        vga_nxt.vblnk  = (v_nxt >= VER_PIXELS);
        vga_nxt.rgb    = BG_COLOR;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vga <= '{hcount: '0, vcount: '0, hsync: 1'b0, vsync: 1'b0,
                     hblnk: 1'b0, vblnk: 1'b0, rgb: BG_COLOR};
        end else begin
            vga <= vga_nxt;
        end
    end

    a_hcount_range: assert property (@(posedge clk) disable iff (rst)
        vga.hcount < HOR_TOTAL);

endmodule

/* hw/mouse_click_sync.sv */
`timescale 1ns/1ps

module mouse_click_sync (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mouse_btn,
    input  logic [11:0]            mouse_x,
    input  logic [11:0]            mouse_y,
    output game_pkg::mouse_evt_t   evt
);
    import game_pkg::*;

    logic        btn_meta;
    logic        btn_sync;
    logic        btn_prev;
    logic        rise;
    logic        click_q;
    logic [11:0] x_q;
    logic [11:0] y_q;

    assign rise = btn_sync & ~btn_prev;

    always_ff @(posedge clk) begin
        if (rst) begin
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
            btn_prev <= 1'b0;
            click_q  <= 1'b0;
        end else begin
            btn_meta <= mouse_btn;
            btn_sync <= btn_meta;
            btn_prev <= btn_sync;
            click_q  <= rise;
        end
    end

    // position is taken on the same edge that raises the click.
    always_ff @(posedge clk) begin
        if (rise) begin
            x_q <= mouse_x;
            y_q <= mouse_y;
        end
    end

    assign evt = '{click: click_q, x: x_q, y: y_q};

    a_click_single: assert property (@(posedge clk) disable iff (rst)
        evt.click |=> !evt.click);

endmodule

/* class_select/sprite_shape.sv */
`timescale 1ns/1ps

module sprite_shape (
    input  game_pkg::char_class_t cls,
    input  logic [11:0]           rel_x,
    input  logic [11:0]           rel_y,
    output logic                  opaque,
    output logic [11:0]           color
);
    import game_pkg::*;

    always_comb begin
        rect_t r;
        logic  hit;

        opaque = 1'b0;
        color  = '0;
        // later entries are drawn on top of earlier ones.
        for (int i = 0; i < N_RECTS; i++) begin
            if (cls == CLASS_ARCHER) begin
                r = ARCHER_RECTS[i];
            end else begin
                r = MELEE_RECTS[i];
            end
            hit = (rel_x >= r.x0) && (rel_x < r.x1) &&
                  (rel_y >= r.y0) && (rel_y < r.y1);
            if (hit && cls != CLASS_NONE) begin
                opaque = 1'b1;
                color  = r.color;
            end
        end
    end

endmodule

/* class_select/class_selector.sv */
`timescale 1ns/1ps

module class_selector (
    input  logic                   clk,
    input  logic                   rst,
    input  game_pkg::game_state_t  state,
    input  game_pkg::mouse_evt_t   evt,
    input  vga_pkg::vga_bus_t      vga_in,
    output vga_pkg::vga_bus_t      vga_out,
    output game_pkg::char_stats_t  stats
);
    import vga_pkg::*;
    import game_pkg::*;

    char_class_t sel_q;
    logic [11:0] px;
    logic [11:0] py;
    logic        in_left;
    logic        in_right;
    logic        in_center;
    logic        on_frame;
    logic        left_opaque;
    logic        right_opaque;
    logic        ctr_opaque;
    logic [11:0] left_color;
    logic [11:0] right_color;
    logic [11:0] ctr_color;
    logic [11:0] rgb_nxt;

    function automatic logic in_box(input logic [11:0] x, input logic [11:0] y,
                                    input int x0, input int y0);
        return (x >= x0) && (x < x0 + RECT_W) && (y >= y0) && (y < y0 + RECT_H);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_q <= CLASS_NONE;
        end else if (state == MENU && evt.click) begin
            if (in_box(evt.x, evt.y, LEFT_X, TOP_Y)) begin
                sel_q <= CLASS_MELEE;
            end else if (in_box(evt.x, evt.y, RIGHT_X, TOP_Y)) begin
                sel_q <= CLASS_ARCHER;
            end
        end
    end

    always_comb begin
        case (sel_q)
            CLASS_MELEE:  stats = '{cls: CLASS_MELEE, hp: MELEE_HP, wpn: WPN_SWORD};
            CLASS_ARCHER: stats = '{cls: CLASS_ARCHER, hp: ARCHER_HP, wpn: WPN_GUN};
            default:      stats = '{cls: sel_q, hp: 4'd0, wpn: WPN_NONE};
        endcase
    end

    assign px        = {1'b0, vga_in.hcount};
    assign py        = {2'b0, vga_in.vcount};
    assign in_left   = in_box(px, py, LEFT_X, TOP_Y);
    assign in_right  = in_box(px, py, RIGHT_X, TOP_Y);
    assign in_center = in_box(px, py, CENTER_X, CENTER_Y);

    sprite_shape u_left_shape (
        .cls    (CLASS_MELEE),
        .rel_x  (12'(px - LEFT_X)),
        .rel_y  (12'(py - TOP_Y)),
        .opaque (left_opaque),
        .color  (left_color)
    );

    sprite_shape u_right_shape (
        .cls    (CLASS_ARCHER),
        .rel_x  (12'(px - RIGHT_X)),
        .rel_y  (12'(py - TOP_Y)),
        .opaque (right_opaque),
        .color  (right_color)
    );

    sprite_shape u_center_shape (
        .cls    (sel_q),
        .rel_x  (12'(px - CENTER_X)),
        .rel_y  (12'(py - CENTER_Y)),
        .opaque (ctr_opaque),
        .color  (ctr_color)
    );

    // the frame is the outer FRAME_W pixels of the centre box.
    assign on_frame = (px < CENTER_X + FRAME_W) || (px >= CENTER_X + RECT_W - FRAME_W) ||
                      (py < CENTER_Y + FRAME_W) || (py >= CENTER_Y + RECT_H - FRAME_W);

    always_comb begin
        rgb_nxt = vga_in.rgb;
        if (state == MENU) begin
            if (in_left && left_opaque) begin
                rgb_nxt = left_color;
            end
            if (in_right && right_opaque) begin
                rgb_nxt = right_color;
            end
            if (in_center) begin
                if (ctr_opaque) begin
                    rgb_nxt = ctr_color;
                end else if (on_frame) begin
                    rgb_nxt = FRAME_COLOR;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        vga_out     <= vga_in;
        vga_out.rgb <= rgb_nxt;
    end

    a_cls_legal: assert property (@(posedge clk) disable iff (rst)
        stats.cls != 2'b11);

endmodule

/* hw/vga_blank_out.sv */
`timescale 1ns/1ps

module vga_blank_out (
    input  logic              clk,
    input  logic              rst,
    input  vga_pkg::vga_bus_t vga_in,
    output vga_pkg::vga_bus_t vga_out
);
    import vga_pkg::*;

    logic blank;

    assign blank = vga_in.hblnk | vga_in.vblnk;

    // the monitor expects black during the blanking intervals.
    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out     <= vga_in;
            vga_out.rgb <= blank ? 12'h000 : vga_in.rgb;
        end
    end

endmodule

/* hw/char_select_top.sv */
`timescale 1ns/1ps

module char_select_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mouse_btn,
    input  logic [11:0]            mouse_x,
    input  logic [11:0]            mouse_y,
    input  game_pkg::game_state_t  state,
    output vga_pkg::vga_bus_t      vga_out,
    output game_pkg::char_stats_t  stats
);
    import vga_pkg::*;
    import game_pkg::*;

    vga_bus_t   timing_bus;
    vga_bus_t   select_bus;
    mouse_evt_t evt;

    vga_timing u_vga_timing (
        .clk (clk),
        .rst (rst),
        .vga (timing_bus)
    );

    mouse_click_sync u_mouse_click_sync (
        .clk       (clk),
        .rst       (rst),
        .mouse_btn (mouse_btn),
        .mouse_x   (mouse_x),
        .mouse_y   (mouse_y),
        .evt       (evt)
    );

    class_selector u_class_selector (
        .clk     (clk),
        .rst     (rst),
        .state   (state),
        .evt     (evt),
        .vga_in  (timing_bus),
        .vga_out (select_bus),
        .stats   (stats)
    );

    vga_blank_out u_vga_blank_out (
        .clk     (clk),
        .rst     (rst),
        .vga_in  (select_bus),
        .vga_out (vga_out)
    );

endmodule

/* verif/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

function automatic logic inside_box(input int x, input int y, input int x0, input int y0);
    return (x >= x0) && (x < x0 + RECT_W) && (y >= y0) && (y < y0 + RECT_H);
endfunction

// bit 12 marks a covered position and bits 11:0 hold the colour of the top rectangle.
function automatic logic [12:0] sprite_at(input char_class_t cls, input int rx, input int ry);
    rect_t       r;
    logic [12:0] res;
    res = '0;
    for (int i = 0; i < N_RECTS; i++) begin
        r = (cls == CLASS_ARCHER) ? ARCHER_RECTS[i] : MELEE_RECTS[i];
        if (cls != CLASS_NONE && rx >= int'(r.x0) && rx < int'(r.x1) &&
            ry >= int'(r.y0) && ry < int'(r.y1)) begin
            res = {1'b1, r.color};
        end
    end
    return res;
endfunction

function automatic logic [11:0] expected_rgb(input int h, input int v,
                                             input char_class_t sel, input game_state_t st);
    logic [12:0] spr;
    int          rx;
    int          ry;
    if (h >= HOR_PIXELS || v >= VER_PIXELS) begin
        return 12'h000;
    end
    if (st != MENU) begin
        return BG_COLOR;
    end
    if (inside_box(h, v, LEFT_X, TOP_Y)) begin
        spr = sprite_at(CLASS_MELEE, h - LEFT_X, v - TOP_Y);
        return spr[12] ? spr[11:0] : BG_COLOR;
    end
    if (inside_box(h, v, RIGHT_X, TOP_Y)) begin
        spr = sprite_at(CLASS_ARCHER, h - RIGHT_X, v - TOP_Y);
        return spr[12] ? spr[11:0] : BG_COLOR;
    end
    if (inside_box(h, v, CENTER_X, CENTER_Y)) begin
        rx  = h - CENTER_X;
        ry  = v - CENTER_Y;
        spr = sprite_at(sel, rx, ry);
        if (spr[12]) begin
            return spr[11:0];
        end
        if (rx < FRAME_W || rx >= RECT_W - FRAME_W || ry < FRAME_W || ry >= RECT_H - FRAME_W) begin
            return FRAME_COLOR;
        end
    end
    return BG_COLOR;
endfunction

// only a click in MENU that lands in one of the two boxes changes the class.
function automatic char_class_t next_class(input char_class_t cur, input game_state_t st,
                                           input int x, input int y);
    if (st != MENU) begin
        return cur;
    end
    if (inside_box(x, y, LEFT_X, TOP_Y)) begin
        return CLASS_MELEE;
    end
    if (inside_box(x, y, RIGHT_X, TOP_Y)) begin
        return CLASS_ARCHER;
    end
    return cur;
endfunction

function automatic char_stats_t expected_stats(input char_class_t cls);
    char_stats_t s;
    s.cls = cls;
    s.hp  = 4'd0;
    s.wpn = WPN_NONE;
    if (cls == CLASS_MELEE) begin
        s.hp  = 4'd10;
        s.wpn = WPN_SWORD;
    end else if (cls == CLASS_ARCHER) begin
        s.hp  = 4'd8;
        s.wpn = WPN_GUN;
    end
    return s;
endfunction

`endif

/* verif/tb_char_select_top.sv */
`timescale 1ns/1ps

module tb_char_select_top;
    import vga_pkg::*;
    import game_pkg::*;

    `include "tb_model.svh"

    localparam int FRAME_CYCLES = HOR_TOTAL * VER_TOTAL;
    // four frame scans at 10 ns per pixel, with 10% margin.
    localparam int WATCHDOG_NS  = 4 * FRAME_CYCLES * 11;

    logic        clk = 1'b0;
    logic        rst;
    logic        mouse_btn;
    logic [11:0] mouse_x;
    logic [11:0] mouse_y;
    game_state_t state;
    vga_bus_t    vga_out;
    char_stats_t stats;

    logic [31:0] lfsr;
    char_class_t model_sel;
    int          errors;
    int          checks;
    int          test_num;
    int          test_errors;
    int          test_checks;

    char_select_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .mouse_btn (mouse_btn),
        .mouse_x   (mouse_x),
        .mouse_y   (mouse_y),
        .state     (state),
        .vga_out   (vga_out),
        .stats     (stats)
    );

    always #5 clk = ~clk;

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic mismatch(input string msg);
        errors++;
        test_errors++;
        if (test_errors <= 8) begin
            $display("[FAIL] %0t ns: %s", $time, msg);
        end
    endtask

    task automatic end_test(input string name);
        test_num++;
        $display("test %0d %s: %0d checks, %0d errors", test_num, name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    // x^32 + x^22 + x^2 + x + 1 in Fibonacci form.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one LFSR step per bit taken.
    task automatic draw_bits(input int n, output logic [11:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[10:0], lfsr[0]};
        end
    endtask

    task automatic check_stats();
        char_stats_t exp;
        exp = expected_stats(model_sel);
        checks++;
        test_checks++;
        if (stats !== exp) begin
            mismatch($sformatf("stats %h, expected %h", stats, exp));
        end
    endtask

    task automatic press(input int x, input int y);
        mouse_x   = 12'(x);
        mouse_y   = 12'(y);
        mouse_btn = 1'b1;
        repeat (8) step();
        mouse_btn = 1'b0;
        repeat (8) step();
        model_sel = next_class(model_sel, state, x, y);
        check_stats();
    endtask

    task automatic random_press();
        logic [11:0] pick;
        logic [11:0] a;
        logic [11:0] b;
        draw_bits(2, pick);
        draw_bits(10, a);
        draw_bits(10, b);
        if (pick == 0) begin
            press(LEFT_X + a % RECT_W, TOP_Y + b % RECT_H);
        end else if (pick == 1) begin
            press(RIGHT_X + a % RECT_W, TOP_Y + b % RECT_H);
        end else begin
            press(a % HOR_PIXELS, b % VER_PIXELS);
        end
    endtask

    // covers every pixel of one frame, starting wherever the scan happens to be.
    task automatic scan_frame(input logic timing_only);
        int          h;
        int          v;
        int          exp_h;
        int          exp_v;
        logic [11:0] exp_rgb;
        exp_h = -1;
        exp_v = -1;
        for (int n = 0; n < FRAME_CYCLES; n++) begin
            step();
            h = vga_out.hcount;
            v = vga_out.vcount;
            checks++;
            test_checks++;
            if (timing_only) begin
                if (exp_h >= 0 && (h != exp_h || v != exp_v)) begin
                    mismatch($sformatf("position %0d,%0d, expected %0d,%0d", h, v, exp_h, exp_v));
                end
                if (vga_out.hsync !== (h >= HOR_SYNC_START && h < HOR_SYNC_END) ||
                    vga_out.vsync !== (v >= VER_SYNC_START && v < VER_SYNC_END)) begin
                    mismatch($sformatf("sync wrong at %0d,%0d", h, v));
                end
                if (vga_out.hblnk !== (h >= HOR_PIXELS) || vga_out.vblnk !== (v >= VER_PIXELS)) begin
                    mismatch($sformatf("blanking wrong at %0d,%0d", h, v));
                end
                if ((vga_out.hblnk || vga_out.vblnk) && vga_out.rgb !== 12'h000) begin
                    mismatch($sformatf("rgb %h during blanking at %0d,%0d", vga_out.rgb, h, v));
                end
            end else begin
                exp_rgb = expected_rgb(h, v, model_sel, state);
                if (vga_out.rgb !== exp_rgb) begin
                    mismatch($sformatf("rgb %h at %0d,%0d, expected %h",
                                       vga_out.rgb, h, v, exp_rgb));
                end
            end
            exp_h = (h + 1) % HOR_TOTAL;
            exp_v = (h == HOR_TOTAL - 1) ? (v + 1) % VER_TOTAL : v;
        end
    endtask

    initial begin
        lfsr        = 32'h0133_b814;
        model_sel   = CLASS_NONE;
        errors      = 0;
        checks      = 0;
        test_num    = 0;
        test_errors = 0;
        test_checks = 0;
        rst         = 1'b1;
        mouse_btn   = 1'b0;
        mouse_x     = '0;
        mouse_y     = '0;
        state       = MENU;
        repeat (4) step();

        check_stats();
        checks++;
        test_checks++;
        if (vga_out.hsync !== 1'b0 || vga_out.vsync !== 1'b0 || vga_out.rgb !== 12'h000) begin
            mismatch($sformatf("sync %b%b rgb %h after reset", vga_out.hsync, vga_out.vsync,
                               vga_out.rgb));
        end
        end_test("reset values");
        rst = 1'b0;
        // the pipeline repeats the reset position for a couple of cycles.
        repeat (3) step();

        scan_frame(1'b1);
        end_test("sync and blanking");
        scan_frame(1'b0);
        end_test("menu frame, no class");

        for (int i = 0; i < 12; i++) begin
            random_press();
        end
        scan_frame(1'b0);
        end_test("random presses and chosen sprite");

        state = PLAYING;
        press(LEFT_X + 10, TOP_Y + 10);
        press(RIGHT_X + 10, TOP_Y + 10);
        scan_frame(1'b0);
        end_test("presses while playing");

        $display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* char_select_top.f */
+incdir+verif
common/vga_pkg.sv
common/game_pkg.sv
hw/vga_timing.sv
hw/mouse_click_sync.sv
class_select/sprite_shape.sv
class_select/class_selector.sv
hw/vga_blank_out.sv
hw/char_select_top.sv
verif/tb_char_select_top.sv
